/* exe_defines.svh */
// Execute stage width parameters shared by the package, the RTL and the testbench
`ifndef EXE_DEFINES_SVH
`define EXE_DEFINES_SVH

//////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////

// Data word and virtual address width
`define EXE_XLEN 32

// Register file address width
`define EXE_REG_ADDR_W 5

// Shift amount field width
`define EXE_SHAMT_W 5

// Byte lanes per data word
`define EXE_BE_W 4

`endif

/* exe_pkg.sv */
// Execute stage package with operation enums and the stage request and response bundles
`default_nettype none

`include "exe_defines.svh"

package exe_pkg;

  //////////////////////////////////////////////////
  // Operation encodings
  //////////////////////////////////////////////////

  // ALU operations, only ADD and SUB trap on overflow
  typedef enum logic [3:0] {
    ADD, ADDU, SUB, SUBU,
    AND, OR, XOR, NOR,
    SLT, SLTU,
    SLL, SRL, SRA,
    LUI
  } alu_op_e;

  // Operand A source
  typedef enum logic [1:0] {
    RS, PC_PLUS4, SHAMT
  } src_a_e;

  // Operand B source
  typedef enum logic [1:0] {
    RT, SIGN_IMM, FOUR, ZERO_IMM
  } src_b_e;

  // Memory access kind and size
  typedef enum logic [3:0] {
    NONE, LB, LBU, LH, LHU, LW, SB, SH, SW
  } mem_op_e;

  //////////////////////////////////////////////////
  // Bundles
  //////////////////////////////////////////////////

  // Fault flags, highest bit first
  typedef struct packed {
    logic pc_adel;
    logic ri;
    logic ovf;
    logic sys;
    logic bp;
    logic adel;
    logic ades;
  } exc_t;

  // Decode to execute
  typedef struct packed {
    logic [`EXE_XLEN-1:0]       pc;
    logic [`EXE_XLEN-1:0]       pc_plus4;
    logic [`EXE_XLEN-1:0]       rs_data;
    logic [`EXE_XLEN-1:0]       rt_data;
    logic [`EXE_SHAMT_W-1:0]    shamt;
    logic [`EXE_XLEN-1:0]       sign_imm;
    logic [`EXE_XLEN-1:0]       zero_imm;
    src_a_e                     src_a;
    src_b_e                     src_b;
    alu_op_e                    alu_op;
    mem_op_e                    mem_op;
    logic [`EXE_REG_ADDR_W-1:0] reg_waddr;
    logic                       reg_write;
    logic                       delay_slot;
    // Decode only raises pc_adel, ri, sys and bp
    exc_t                       exc;
  } exe_req_t;

  // Execute to memory
  typedef struct packed {
    logic [`EXE_XLEN-1:0]       pc;
    logic [`EXE_XLEN-1:0]       alu_result;
    logic [`EXE_XLEN-1:0]       mem_wdata;
    logic [`EXE_BE_W-1:0]       byte_en;
    mem_op_e                    mem_op;
    logic [`EXE_REG_ADDR_W-1:0] reg_waddr;
    logic                       reg_write;
    exc_t                       exc;
    logic [`EXE_XLEN-1:0]       bad_vaddr;
    logic                       delay_slot;
  } exe_rsp_t;

endpackage

`default_nettype wire

/* exe_operand_sel.sv */
// ALU operand selection from register data, PC+4, shift amount and immediates
`default_nettype none
`timescale 1ns/10ps

`include "exe_defines.svh"

module exe_operand_sel (
  input  exe_pkg::exe_req_t    req,
  output logic [`EXE_XLEN-1:0] a,
  output logic [`EXE_XLEN-1:0] b
);

  import exe_pkg::*;

  // Shift amount zero-extended to a full word
  logic [`EXE_XLEN-1:0] shamt_ext;

  assign shamt_ext = {{(`EXE_XLEN - `EXE_SHAMT_W){1'b0}}, req.shamt};

  // Operand A
  always_comb begin
    case (req.src_a)
      RS:       a = req.rs_data;
      PC_PLUS4: a = req.pc_plus4;
      SHAMT:    a = shamt_ext;
      default:  a = '0;
    endcase
  end

  // Operand B, FOUR serves the link address calculation
  always_comb begin
    case (req.src_b)
      RT:       b = req.rt_data;
      SIGN_IMM: b = req.sign_imm;
      FOUR:     b = `EXE_XLEN'(4);
      ZERO_IMM: b = req.zero_imm;
      default:  b = '0;
    endcase
  end

endmodule

`default_nettype wire

/* exe_alu.sv */
// Execute ALU with shared adder, shifter and comparator plus signed overflow detection
`default_nettype none
`timescale 1ns/10ps

`include "exe_defines.svh"

module exe_alu (
  input  logic [`EXE_XLEN-1:0] a,
  input  logic [`EXE_XLEN-1:0] b,
  input  exe_pkg::alu_op_e     op,
  output logic [`EXE_XLEN-1:0] result,
  output logic                 overflow
);

  import exe_pkg::*;

  localparam int XLEN = `EXE_XLEN;
  localparam int HALF = XLEN / 2;
  localparam int MSB  = XLEN - 1;

  logic                    is_sub;
  logic [XLEN-1:0]         b_eff;
  logic [XLEN-1:0]         sum;
  logic                    carry_out;
  logic                    carry_msb;
  logic                    lt_signed;
  logic                    lt_unsigned;
  logic [`EXE_SHAMT_W-1:0] sh;

  //////////////////////////////////////////////////
  // Shared adder and subtracter
  //////////////////////////////////////////////////

  // Compares reuse the subtract path
  assign is_sub = (op == SUB) || (op == SUBU) || (op == SLT) || (op == SLTU);
  assign b_eff  = is_sub ? ~b : b;

  assign {carry_out, sum} = {1'b0, a} + {1'b0, b_eff} + {{XLEN{1'b0}}, is_sub};

  // Carry into the sign bit, recovered from the sum
  assign carry_msb = sum[MSB] ^ a[MSB] ^ b_eff[MSB];

  // Trap only on the signed forms
  assign overflow = ((op == ADD) || (op == SUB)) && (carry_msb ^ carry_out);

  //////////////////////////////////////////////////
  // Comparator
  //////////////////////////////////////////////////

  // Differing signs decide directly, otherwise the difference sign does
  assign lt_signed   = (a[MSB] != b[MSB]) ? a[MSB] : sum[MSB];
  // No borrow out of a - b means a >= b
  assign lt_unsigned = ~carry_out;

  // Shifts move B by the low bits of A
  assign sh = a[`EXE_SHAMT_W-1:0];

  //////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////

  always_comb begin
    case (op)
      ADD, ADDU, SUB, SUBU: result = sum;
      AND:     result = a & b;
      OR:      result = a | b;
      XOR:     result = a ^ b;
      NOR:     result = ~(a | b);
      SLT:     result = {{(XLEN - 1){1'b0}}, lt_signed};
      SLTU:    result = {{(XLEN - 1){1'b0}}, lt_unsigned};
      SLL:     result = b << sh;
      SRL:     result = b >> sh;
      SRA:     result = $signed(b) >>> sh;
      LUI:     result = {b[HALF-1:0], {HALF{1'b0}}};
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* exe_mem_align.sv */
// Store lane enables, store data alignment and address alignment fault detection
`default_nettype none
`timescale 1ns/10ps

`include "exe_defines.svh"

module exe_mem_align (
  input  exe_pkg::mem_op_e      mem_op,
  input  logic [1:0]            addr_lo,
  input  logic [`EXE_XLEN-1:0]  rt_data,
  output logic [`EXE_BE_W-1:0]  byte_en,
  output logic [`EXE_XLEN-1:0]  wdata,
  output logic                  adel,
  output logic                  ades
);

  import exe_pkg::*;

  localparam int XLEN = `EXE_XLEN;
  localparam int BE_W = `EXE_BE_W;

  logic [BE_W-1:0] be_byte;
  logic [BE_W-1:0] be_half;
  logic [XLEN-1:0] data_byte;
  logic [XLEN-1:0] data_half;

  // One lane for bytes, a lane pair for halfwords picked by bit 1
  assign be_byte = {{(BE_W - 1){1'b0}}, 1'b1} << addr_lo;
  assign be_half = {{(BE_W - 2){1'b0}}, 2'b11} << {addr_lo[1], 1'b0};

  // Low byte or half moved into the addressed lanes, rest zero
  assign data_byte = {{(XLEN - 8){1'b0}}, rt_data[7:0]} << {addr_lo, 3'b000};
  assign data_half = {{(XLEN - 16){1'b0}}, rt_data[15:0]} << {addr_lo[1], 4'b0000};

  always_comb begin
    case (mem_op)
      SB: begin
        byte_en = be_byte;
        wdata   = data_byte;
      end
      SH: begin
        byte_en = be_half;
        wdata   = data_half;
      end
      SW: begin
        byte_en = '1;
        wdata   = rt_data;
      end
      // Loads and NONE write nothing
      default: begin
        byte_en = '0;
        wdata   = '0;
      end
    endcase
  end

  // Halfwords need bit 0 clear, words need both low bits clear
  assign adel = (((mem_op == LH) || (mem_op == LHU)) && addr_lo[0]) ||
                ((mem_op == LW) && (|addr_lo));
  assign ades = ((mem_op == SH) && addr_lo[0]) ||
                ((mem_op == SW) && (|addr_lo));

endmodule

`default_nettype wire

/* execute_stage.sv */
// Pipeline execute stage with valid/allow-in handshake, fault merging and EX/MEM register
`default_nettype none
`timescale 1ns/10ps

`include "exe_defines.svh"

module execute_stage (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid,
  input  exe_pkg::exe_req_t   in_req,
  output logic                in_allowin,
  output logic                out_valid,
  output exe_pkg::exe_rsp_t   out_rsp,
  input  logic                out_allowin
);

  import exe_pkg::*;

  logic                 valid_q;
  exe_rsp_t             rsp_q;
  exe_rsp_t             rsp_d;
  logic                 in_fire;

  logic [`EXE_XLEN-1:0] op_a;
  logic [`EXE_XLEN-1:0] op_b;
  logic [`EXE_XLEN-1:0] alu_result;
  logic                 alu_ovf;
  logic [`EXE_BE_W-1:0] st_byte_en;
  logic [`EXE_XLEN-1:0] st_wdata;
  logic                 adel;
  logic                 ades;
  exc_t                 exc_d;
  logic                 any_exc;

  //////////////////////////////////////////////////
  // Handshake
  //////////////////////////////////////////////////

  // Single entry, so accept when empty or when the held item leaves now
  assign in_allowin = !valid_q || out_allowin;
  assign in_fire    = in_valid && in_allowin;
  assign out_valid  = valid_q;
  assign out_rsp    = rsp_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (in_allowin) begin
      valid_q <= in_valid;
    end
  end

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  exe_operand_sel i_operand_sel (
    .req (in_req),
    .a   (op_a),
    .b   (op_b)
  );

  exe_alu i_alu (
    .a        (op_a),
    .b        (op_b),
    .op       (in_req.alu_op),
    .result   (alu_result),
    .overflow (alu_ovf)
  );

  // Low address bits come straight from the ALU sum
  exe_mem_align i_mem_align (
    .mem_op  (in_req.mem_op),
    .addr_lo (alu_result[1:0]),
    .rt_data (in_req.rt_data),
    .byte_en (st_byte_en),
    .wdata   (st_wdata),
    .adel    (adel),
    .ades    (ades)
  );

  //////////////////////////////////////////////////
  // Fault merge and response build
  //////////////////////////////////////////////////

  always_comb begin
    exc_d      = in_req.exc;
    exc_d.ovf  = in_req.exc.ovf | alu_ovf;
    exc_d.adel = in_req.exc.adel | adel;
    exc_d.ades = in_req.exc.ades | ades;
  end

  assign any_exc = |exc_d;

  always_comb begin
    rsp_d            = '0;
    rsp_d.pc         = in_req.pc;
    rsp_d.alu_result = alu_result;
    rsp_d.mem_wdata  = st_wdata;
    rsp_d.mem_op     = in_req.mem_op;
    rsp_d.reg_waddr  = in_req.reg_waddr;
    rsp_d.exc        = exc_d;
    rsp_d.delay_slot = in_req.delay_slot;
    // A faulting instruction must not touch registers or memory
    rsp_d.reg_write  = in_req.reg_write & ~any_exc;
    rsp_d.byte_en    = any_exc ? '0 : st_byte_en;
    // Fetch fault takes priority over data address faults
    if (exc_d.pc_adel) begin
      rsp_d.bad_vaddr = in_req.pc;
    end else if (exc_d.adel || exc_d.ades) begin
      rsp_d.bad_vaddr = alu_result;
    end
  end

  // EX/MEM register, cleared so memory sees a zero bundle out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_q <= '0;
    end else if (in_fire) begin
      rsp_q <= rsp_d;
    end
  end

endmodule

`default_nettype wire

/* tb_execute_stage.sv */
// Self-checking testbench for the execute stage with an in-file reference model and watchdog
`default_nettype none
`timescale 1ns/10ps

`include "exe_defines.svh"

module tb_execute_stage;

  import exe_pkg::*;

  localparam int CLK_PERIOD          = 20;
  localparam int MSB                 = `EXE_XLEN - 1;
  // About 210 transfers of two cycles each, with generous slack
  localparam int NUM_TRANSFERS       = 210;
  localparam int CYCLES_PER_TRANSFER = 2;
  localparam int MARGIN              = 4;
  localparam int WATCHDOG_CYCLES     = NUM_TRANSFERS * CYCLES_PER_TRANSFER * MARGIN;

  logic     clk;
  logic     rst;
  logic     in_valid;
  exe_req_t in_req;
  logic     in_allowin;
  logic     out_valid;
  exe_rsp_t out_rsp;
  logic     out_allowin;

  execute_stage i_dut (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .in_req      (in_req),
    .in_allowin  (in_allowin),
    .out_valid   (out_valid),
    .out_rsp     (out_rsp),
    .out_allowin (out_allowin)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired before the tests finished");
    $display("Test failed");
    $fatal(1, "Simulation hung");
  end

  //////////////////////////////////////////////////
  // Reference model and checkers
  //////////////////////////////////////////////////

  function automatic exe_rsp_t expected_rsp(input exe_req_t r);
    exe_rsp_t             e;
    logic [`EXE_XLEN-1:0] a;
    logic [`EXE_XLEN-1:0] b;
    logic [`EXE_XLEN-1:0] res;
    logic [`EXE_XLEN-1:0] lanes;
    logic [`EXE_BE_W-1:0] be;
    logic                 ovf;
    e = '0;
    case (r.src_a)
      PC_PLUS4: a = r.pc_plus4;
      SHAMT:    a = 32'(r.shamt);
      default:  a = r.rs_data;
    endcase
    case (r.src_b)
      SIGN_IMM: b = r.sign_imm;
      FOUR:     b = 32'd4;
      ZERO_IMM: b = r.zero_imm;
      default:  b = r.rt_data;
    endcase
    case (r.alu_op)
      ADD, ADDU: res = a + b;
      SUB, SUBU: res = a - b;
      AND:       res = a & b;
      OR:        res = a | b;
      XOR:       res = a ^ b;
      NOR:       res = ~a & ~b;
      SLT:       res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      SLTU:      res = (a < b) ? 32'd1 : 32'd0;
      SLL:       res = b << a[4:0];
      SRL:       res = b >> a[4:0];
      SRA:       res = $signed(b) >>> a[4:0];
      default:   res = {b[15:0], 16'h0000};
    endcase
    // Same-sign inputs giving a result of the other sign
    ovf = 1'b0;
    if (r.alu_op == ADD) ovf = (a[MSB] == b[MSB]) && (res[MSB] != a[MSB]);
    if (r.alu_op == SUB) ovf = (a[MSB] != b[MSB]) && (res[MSB] != a[MSB]);
    be    = '0;
    lanes = '0;
    case (r.mem_op)
      SB: begin
        be    = 4'b0001 << res[1:0];
        lanes = {4{r.rt_data[7:0]}};
      end
      SH: begin
        be    = res[1] ? 4'b1100 : 4'b0011;
        lanes = {2{r.rt_data[15:0]}};
      end
      SW: begin
        be    = 4'b1111;
        lanes = r.rt_data;
      end
      default: ;
    endcase
    // Lanes outside the enables carry zero
    for (int i = 0; i < `EXE_BE_W; i++) begin
      if (!be[i]) lanes[8*i +: 8] = 8'h00;
    end
    e.exc      = r.exc;
    e.exc.ovf  = r.exc.ovf | ovf;
    e.exc.adel = r.exc.adel | ((r.mem_op inside {LH, LHU}) && res[0]) ||
                 ((r.mem_op == LW) && (res[1:0] != 2'b00));
    e.exc.ades = r.exc.ades | ((r.mem_op == SH) && res[0]) ||
                 ((r.mem_op == SW) && (res[1:0] != 2'b00));
    e.pc         = r.pc;
    e.alu_result = res;
    e.mem_wdata  = lanes;
    e.mem_op     = r.mem_op;
    e.reg_waddr  = r.reg_waddr;
    e.delay_slot = r.delay_slot;
    if (e.exc != '0) begin
      e.reg_write = 1'b0;
      e.byte_en   = '0;
    end else begin
      e.reg_write = r.reg_write;
      e.byte_en   = be;
    end
    if (e.exc.pc_adel) e.bad_vaddr = r.pc;
    else if (e.exc.adel || e.exc.ades) e.bad_vaddr = res;
    return e;
  endfunction

  task automatic check_value(input logic [`EXE_XLEN-1:0] got, input logic [`EXE_XLEN-1:0] exp,
                             input string what);
    assert (got === exp) else begin
      $display("Fail at %0t ns: %s got %h expected %h", $time, what, got, exp);
      $display("Test failed");
      $fatal(1, "Mismatch in %s", what);
    end
  endtask

  task automatic compare_rsp(input exe_rsp_t got, input exe_rsp_t exp, input string tag);
    check_value(got.pc, exp.pc, {tag, " pc"});
    check_value(got.alu_result, exp.alu_result, {tag, " alu_result"});
    check_value(got.mem_wdata, exp.mem_wdata, {tag, " mem_wdata"});
    check_value(32'(got.byte_en), 32'(exp.byte_en), {tag, " byte_en"});
    check_value(32'(got.mem_op), 32'(exp.mem_op), {tag, " mem_op"});
    check_value(32'(got.reg_waddr), 32'(exp.reg_waddr), {tag, " reg_waddr"});
    check_value(32'(got.reg_write), 32'(exp.reg_write), {tag, " reg_write"});
    check_value(32'(got.exc), 32'(exp.exc), {tag, " exc"});
    check_value(got.bad_vaddr, exp.bad_vaddr, {tag, " bad_vaddr"});
    check_value(32'(got.delay_slot), 32'(exp.delay_slot), {tag, " delay_slot"});
  endtask

  // Random request with no fault, no memory access and ADDU of rs and rt
  function automatic exe_req_t make_request();
    exe_req_t    r;
    logic [15:0] imm;
    r            = '0;
    imm          = 16'($urandom());
    r.pc         = $urandom() & 32'hFFFF_FFFC;
    r.pc_plus4   = r.pc + 32'd4;
    r.rs_data    = $urandom();
    r.rt_data    = $urandom();
    r.shamt      = 5'($urandom());
    r.sign_imm   = {{16{imm[15]}}, imm};
    r.zero_imm   = {16'h0000, imm};
    r.src_a      = RS;
    r.src_b      = RT;
    r.alu_op     = ADDU;
    r.mem_op     = NONE;
    r.reg_waddr  = 5'($urandom());
    r.reg_write  = 1'b1;
    r.delay_slot = 1'($urandom());
    return r;
  endfunction

  // One transfer in, then the response must be there one cycle later
  task automatic send_and_check(input exe_req_t req);
    exe_rsp_t exp;
    exp = expected_rsp(req);
    @(posedge clk);
    in_valid <= 1'b1;
    in_req   <= req;
    @(negedge clk);
    while (!in_allowin) @(negedge clk);
    @(posedge clk);
    in_valid <= 1'b0;
    @(negedge clk);
    check_value(32'(out_valid), 32'd1, "out_valid one cycle after accept");
    compare_rsp(out_rsp, exp, "response");
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic test_alu_ops();
    exe_req_t r;
    for (int op = 0; op <= int'(LUI); op++) begin
      for (int sa = 0; sa < 3; sa++) begin
        for (int sb = 0; sb < 4; sb++) begin
          r        = make_request();
          r.alu_op = alu_op_e'(op);
          r.src_a  = src_a_e'(sa);
          r.src_b  = src_b_e'(sb);
          send_and_check(r);
        end
      end
    end
    // Negative against positive splits signed and unsigned compares
    r         = make_request();
    r.rs_data = 32'hFFFF_FFFE;
    r.rt_data = 32'd1;
    r.alu_op  = SLT;
    send_and_check(r);
    check_value(out_rsp.alu_result, 32'd1, "SLT of -2 and 1");
    r.alu_op = SLTU;
    send_and_check(r);
    check_value(out_rsp.alu_result, 32'd0, "SLTU of -2 and 1");
    r.rt_data = 32'h8000_0000;
    r.shamt   = 5'd4;
    r.src_a   = SHAMT;
    r.alu_op  = SRA;
    send_and_check(r);
    check_value(out_rsp.alu_result, 32'hF800_0000, "SRA by shamt 4");
  endtask

  task automatic test_overflow();
    exe_req_t r;
    r = make_request();
    for (int i = 0; i < 4; i++) begin
      r.alu_op  = (i == 0) ? ADD : (i == 1) ? ADDU : (i == 2) ? SUB : SUBU;
      r.rs_data = (i < 2) ? 32'h7FFF_FFFF : 32'h8000_0000;
      r.rt_data = 32'd1;
      send_and_check(r);
      check_value(32'(out_rsp.exc.ovf), (i % 2 == 0) ? 32'd1 : 32'd0, "ovf at signed limit");
      check_value(32'(out_rsp.reg_write), (i % 2 == 0) ? 32'd0 : 32'd1, "reg_write at limit");
    end
  endtask

  task automatic test_stores();
    exe_req_t r;
    r         = make_request();
    r.rs_data = r.rs_data & 32'hFFFF_FFFC;
    r.src_b   = SIGN_IMM;
    for (int off = 0; off < 4; off++) begin
      r.mem_op   = SB;
      r.sign_imm = 32'(off);
      send_and_check(r);
      check_value(32'(out_rsp.byte_en), 32'(4'b0001 << off), "SB lane enable");
      check_value(32'(out_rsp.exc), 32'd0, "SB fault flags");
    end
    for (int off = 0; off < 4; off += 2) begin
      r.mem_op   = SH;
      r.sign_imm = 32'(off);
      send_and_check(r);
      check_value(32'(out_rsp.exc), 32'd0, "SH fault flags");
    end
    r.mem_op   = SW;
    r.sign_imm = 32'd0;
    send_and_check(r);
    check_value(out_rsp.mem_wdata, r.rt_data, "SW data");
  endtask

  task automatic test_faults();
    exe_req_t             r;
    mem_op_e              fault_ops [5];
    logic [`EXE_XLEN-1:0] addr;
    logic                 misaligned;
    logic                 is_store;
    fault_ops = '{LH, LHU, LW, SH, SW};
    r         = make_request();
    r.rs_data = r.rs_data & 32'hFFFF_FFFC;
    r.src_b   = SIGN_IMM;
    foreach (fault_ops[i]) begin
      for (int off = 1; off < 4; off++) begin
        r.mem_op   = fault_ops[i];
        r.sign_imm = 32'(off);
        addr       = r.rs_data + 32'(off);
        // Halfwords fault on odd offsets, words on any nonzero offset
        misaligned = ((off % 2) == 1) || (fault_ops[i] inside {LW, SW});
        is_store   = fault_ops[i] inside {SH, SW};
        send_and_check(r);
        if (misaligned) begin
          check_value(32'(out_rsp.exc.adel), 32'(!is_store), "adel on misalign");
          check_value(32'(out_rsp.exc.ades), 32'(is_store), "ades on misalign");
          check_value(out_rsp.bad_vaddr, addr, "bad_vaddr on misalign");
          check_value(32'(out_rsp.byte_en), 32'd0, "byte_en on misalign");
        end
      end
    end
    for (int off = 0; off < 4; off++) begin
      r.mem_op   = LB;
      r.sign_imm = 32'(off);
      send_and_check(r);
      check_value(32'(out_rsp.exc), 32'd0, "LB fault flags");
    end
    r             = make_request();
    r.exc.pc_adel = 1'b1;
    send_and_check(r);
    check_value(out_rsp.bad_vaddr, r.pc, "bad_vaddr on fetch fault");
    for (int i = 0; i < 3; i++) begin
      r       = make_request();
      r.exc   = '0;
      r.exc.ri  = (i == 0);
      r.exc.sys = (i == 1);
      r.exc.bp  = (i == 2);
      send_and_check(r);
      check_value(32'(out_rsp.exc), 32'(r.exc), "decode fault passthrough");
    end
  endtask

  task automatic test_backpressure();
    exe_req_t req;
    exe_req_t next_req;
    exe_rsp_t exp;
    req      = make_request();
    next_req = make_request();
    exp      = expected_rsp(req);
    @(posedge clk);
    out_allowin <= 1'b0;
    send_and_check(req);
    // A second request waits at the input while the output is blocked
    @(posedge clk);
    in_valid <= 1'b1;
    in_req   <= next_req;
    repeat (4) begin
      @(negedge clk);
      check_value(32'(out_valid), 32'd1, "out_valid under back-pressure");
      check_value(32'(in_allowin), 32'd0, "in_allowin under back-pressure");
      compare_rsp(out_rsp, exp, "held response");
    end
    @(posedge clk);
    out_allowin <= 1'b1;
    @(negedge clk);
    check_value(32'(out_valid), 32'd1, "out_valid at release");
    check_value(32'(in_allowin), 32'd1, "in_allowin at release");
    compare_rsp(out_rsp, exp, "response at release");
    @(posedge clk);
    in_valid <= 1'b0;
    @(negedge clk);
    check_value(32'(out_valid), 32'd1, "out_valid after release");
    compare_rsp(out_rsp, expected_rsp(next_req), "queued response");
    @(negedge clk);
    check_value(32'(out_valid), 32'd0, "out_valid after single transfer");
  endtask

  task automatic test_back_to_back();
    exe_req_t reqs [3];
    foreach (reqs[i]) reqs[i] = make_request();
    @(posedge clk);
    in_valid <= 1'b1;
    in_req   <= reqs[0];
    for (int i = 0; i < 3; i++) begin
      @(posedge clk);
      if (i < 2) in_req <= reqs[i + 1];
      else in_valid <= 1'b0;
      @(negedge clk);
      check_value(32'(in_allowin), 32'd1, "in_allowin with free output");
      check_value(32'(out_valid), 32'd1, "out_valid back-to-back");
      compare_rsp(out_rsp, expected_rsp(reqs[i]), "back-to-back response");
    end
    @(negedge clk);
    check_value(32'(out_valid), 32'd0, "out_valid after burst");
  endtask

  initial begin
    void'($urandom(32'h8e42));
    rst         <= 1'b1;
    in_valid    <= 1'b0;
    in_req      <= '0;
    out_allowin <= 1'b0;
    repeat (2) @(posedge clk);
    rst         <= 1'b0;
    out_allowin <= 1'b1;
    @(negedge clk);
    check_value(32'(out_valid), 32'd0, "out_valid after reset");
    compare_rsp(out_rsp, '0, "reset response");
    test_alu_ops();
    test_overflow();
    test_stores();
    test_faults();
    test_backpressure();
    test_back_to_back();
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+.
exe_pkg.sv
exe_operand_sel.sv
exe_alu.sv
exe_mem_align.sv
execute_stage.sv
tb_execute_stage.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_execute_stage \
  -o sim_exe > build.log 2>&1 && ./obj_dir/sim_exe > sim.log 2>&1
grep -qx "Test passed" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }
